/* rtl/ltc_adc_pkg.sv */
package ltc_adc_pkg;

   //////////////////////////////////////////////////////////////////////
   // conversion frame from the ADC
   //////////////////////////////////////////////////////////////////////
   localparam int FRAME_BITS = 24;                     // bits per cnv frame
   localparam int BIT_CNT_W  = $clog2(FRAME_BITS + 1); // scko edge counter width
   localparam int N_CHAN     = 8;
   localparam int CHAN_W     = $clog2(N_CHAN);
   localparam int CHAN_LSB   = 3;                      // chan id at frame[5:3]
   localparam int SUM_LSB    = 6;                      // below: chan id + softspan

   typedef logic [FRAME_BITS-1:0] adc_word_t;          // 18b result, chan, span
   typedef logic [CHAN_W-1:0]     chan_id_t;
   typedef logic [BIT_CNT_W-1:0]  bit_cnt_t;

   //////////////////////////////////////////////////////////////////////
   // result FIFO
   //////////////////////////////////////////////////////////////////////
   localparam int FIFO_W     = 32;
   localparam int FIFO_DEPTH = 16;
   localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

   typedef logic [FIFO_W-1:0]     fifo_word_t;         // extended frame or a sum
   typedef logic [FIFO_PTR_W:0]   fifo_count_t;        // 0 .. FIFO_DEPTH
   typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;

   // frame to fifo word, sign taken from bit 23
   function automatic fifo_word_t sign_ext(adc_word_t w);
      return {{(FIFO_W - FRAME_BITS){w[FRAME_BITS-1]}}, w};
   endfunction

endpackage

/* rtl/ltc_reg_pkg.sv */
package ltc_reg_pkg;

   //////////////////////////////////////////////////////////////////////
   // AXI4-Lite widths
   //////////////////////////////////////////////////////////////////////
   localparam int AXI_ADDR_W = 4;
   localparam int AXI_DATA_W = 32;

   typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
   typedef logic [AXI_DATA_W-1:0] axi_data_t;
   typedef logic [1:0]            axi_resp_t;

   localparam axi_resp_t AXI_RESP_OKAY = 2'b00;

   //////////////////////////////////////////////////////////////////////
   // register map, byte addresses
   //////////////////////////////////////////////////////////////////////
   localparam axi_addr_t REG_CTRL       = 4'h0;  // reset, enable
   localparam axi_addr_t REG_OCC        = 4'h4;  // fifo occupancy, read only
   localparam axi_addr_t REG_INTR_DEPTH = 4'h8;  // irq when count above this
   localparam axi_addr_t REG_NSUM       = 4'hc;  // samples per sum, 0 = raw

   localparam int CTRL_RESET_BIT  = 0;           // self clearing
   localparam int CTRL_ENABLE_BIT = 1;

   typedef logic [31:0] nsum_t;

   // values after reset
   localparam int    INTR_DEPTH_DEFAULT = 1;
   localparam nsum_t NSUM_DEFAULT       = '0;

endpackage

/* rtl/adc_capture.sv */
`timescale 1ns/1ps

module adc_capture
(
   input  logic                   clk,
   input  logic                   aresetn_local,
   input  logic                   cnv,
   input  logic                   scko,
   input  logic                   sdo,
   input  logic                   timetrig,
   input  logic                   soft_clear,
   output logic                   sample_valid,
   output ltc_adc_pkg::adc_word_t sample
);

   logic [2:0]                          pin_s1;     // {cnv, scko, sdo} stage 1
   logic [2:0]                          pin_s2;     // stage 2, safe to use
   logic                                cnv_d;
   logic                                scko_d;
   logic                                cnv_rise;   // new conversion
   logic                                scko_edge;  // either edge, DDR data
   logic                                sdo_bit;    // aligned with scko_edge
   logic [ltc_adc_pkg::FRAME_BITS-2:0]  shift_q;    // last bit joins at frame end
   ltc_adc_pkg::bit_cnt_t               bit_cnt;
   logic                                skip;       // drop next frame after trigger
   logic                                frame_done;

   //////////////////////////////////////////////////////////////////////
   // synchronizer and edge detect, 3 clk from pins
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk or negedge aresetn_local)
   begin
      if (!aresetn_local)
      begin
         pin_s1    <= '0;
         pin_s2    <= '0;
         cnv_d     <= 1'b0;
         scko_d    <= 1'b0;
         cnv_rise  <= 1'b0;
         scko_edge <= 1'b0;
         sdo_bit   <= 1'b0;
      end
      else
      begin
         pin_s1    <= {cnv, scko, sdo};
         pin_s2    <= pin_s1;
         cnv_d     <= pin_s2[2];
         scko_d    <= pin_s2[1];
         cnv_rise  <= pin_s2[2] & ~cnv_d;
         scko_edge <= pin_s2[1] ^ scko_d;  // rise or fall
         sdo_bit   <= pin_s2[0];            // same depth as the edge flag
      end
   end

   assign frame_done = scko_edge &&
      (bit_cnt == ltc_adc_pkg::bit_cnt_t'(ltc_adc_pkg::FRAME_BITS - 1));

   always_ff @(posedge clk or negedge aresetn_local)
   begin
      if (!aresetn_local)
      begin
         bit_cnt      <= '0;
         skip         <= 1'b0;
         sample_valid <= 1'b0;
      end
      else if (soft_clear)
      begin
         bit_cnt      <= '0;
         skip         <= 1'b0;
         sample_valid <= 1'b0;
      end
      else
      begin
         sample_valid <= frame_done & ~skip;  // suppressed frame gives no pulse
         if (cnv_rise)
            bit_cnt <= '0;
         else if (scko_edge && bit_cnt != ltc_adc_pkg::bit_cnt_t'(ltc_adc_pkg::FRAME_BITS))
            bit_cnt <= bit_cnt + 1'b1;          // stops at 24 until next cnv
         if (timetrig)
            skip <= 1'b1;
         else if (frame_done)
            skip <= 1'b0;
      end
   end

   // deserializer, msb first
   always_ff @(posedge clk)
   begin
      if (scko_edge)
         shift_q <= {shift_q[ltc_adc_pkg::FRAME_BITS-3:0], sdo_bit};
      if (frame_done)
         sample <= {shift_q, sdo_bit};
   end

   // at most one frame per pulse, frames need 24 scko edges
   a_valid_single : assert property (@(posedge clk) disable iff (!aresetn_local)
      sample_valid |=> !sample_valid);

endmodule

/* rtl/ltc_regs.sv */
`timescale 1ns/1ps

module ltc_regs
(
   input  logic                     clk,
   input  logic                     aresetn_local,
   input  logic                     awvalid,
   output logic                     awready,
   input  ltc_reg_pkg::axi_addr_t   awaddr,
   input  logic                     wvalid,
   output logic                     wready,
   input  ltc_reg_pkg::axi_data_t   wdata,
   output logic                     bvalid,
   input  logic                     bready,
   output ltc_reg_pkg::axi_resp_t   bresp,
   input  logic                     arvalid,
   output logic                     arready,
   input  ltc_reg_pkg::axi_addr_t   araddr,
   output logic                     rvalid,
   input  logic                     rready,
   output ltc_reg_pkg::axi_data_t   rdata,
   output ltc_reg_pkg::axi_resp_t   rresp,
   input  ltc_adc_pkg::fifo_count_t fifo_count,
   output logic                     enable,
   output logic                     soft_clear,
   output ltc_adc_pkg::fifo_count_t intr_depth,
   output ltc_reg_pkg::nsum_t       nsum
);

   typedef enum logic [1:0] {st_idle, st_wresp, st_rdata} state_t;

   state_t                 state;
   logic                   ctrl_reset;  // high one cycle after a write
   logic                   start_ok;    // free to accept a transfer
   logic                   wr_hs;       // aw and w taken at this edge
   logic                   rd_hs;
   ltc_reg_pkg::axi_data_t rd_mux;

   assign start_ok   = (state == st_idle) && !awready && !arready;
   assign wr_hs      = awready && awvalid && wvalid;
   assign rd_hs      = arready && arvalid;
   assign bresp      = ltc_reg_pkg::AXI_RESP_OKAY;
   assign rresp      = ltc_reg_pkg::AXI_RESP_OKAY;
   assign soft_clear = ctrl_reset;

   //////////////////////////////////////////////////////////////////////
   // handshake FSM
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk or negedge aresetn_local)
   begin
      if (!aresetn_local)
      begin
         state   <= st_idle;
         awready <= 1'b0;
         wready  <= 1'b0;
         arready <= 1'b0;
         bvalid  <= 1'b0;
         rvalid  <= 1'b0;
      end
      else
      begin
         awready <= start_ok && awvalid && wvalid;             // one cycle pulse
         wready  <= start_ok && awvalid && wvalid;
         arready <= start_ok && arvalid && !(awvalid && wvalid);  // write wins
         case (state)
            st_idle:
            begin
               if (wr_hs)
               begin
                  bvalid <= 1'b1;
                  state  <= st_wresp;
               end
               else if (rd_hs)
               begin
                  rvalid <= 1'b1;
                  state  <= st_rdata;
               end
            end
            st_wresp:
            begin
               if (bready)
               begin
                  bvalid <= 1'b0;
                  state  <= st_idle;
               end
            end
            st_rdata:
            begin
               if (rready)
               begin
                  rvalid <= 1'b0;
                  state  <= st_idle;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   // register writes
   always_ff @(posedge clk or negedge aresetn_local)
   begin
      if (!aresetn_local)
      begin
         ctrl_reset <= 1'b0;
         enable     <= 1'b0;
         intr_depth <= ltc_adc_pkg::fifo_count_t'(ltc_reg_pkg::INTR_DEPTH_DEFAULT);
         nsum       <= ltc_reg_pkg::NSUM_DEFAULT;
      end
      else
      begin
         ctrl_reset <= 1'b0;  // self clearing
         if (wr_hs)
         begin
            case (awaddr)
               ltc_reg_pkg::REG_CTRL:
               begin
                  ctrl_reset <= wdata[ltc_reg_pkg::CTRL_RESET_BIT];
                  enable     <= wdata[ltc_reg_pkg::CTRL_ENABLE_BIT];
               end
               ltc_reg_pkg::REG_INTR_DEPTH: intr_depth <= ltc_adc_pkg::fifo_count_t'(wdata);
               ltc_reg_pkg::REG_NSUM:       nsum       <= wdata;
               default: ;                   // occupancy is read only
            endcase
         end
      end
   end

   // read mux
   always_comb
   begin
      rd_mux = '0;
      case (araddr)
         ltc_reg_pkg::REG_CTRL:
         begin
            rd_mux[ltc_reg_pkg::CTRL_RESET_BIT]  = ctrl_reset;
            rd_mux[ltc_reg_pkg::CTRL_ENABLE_BIT] = enable;
         end
         ltc_reg_pkg::REG_OCC:        rd_mux = ltc_reg_pkg::axi_data_t'(fifo_count);
         ltc_reg_pkg::REG_INTR_DEPTH: rd_mux = ltc_reg_pkg::axi_data_t'(intr_depth);
         ltc_reg_pkg::REG_NSUM:       rd_mux = nsum;
         default: ;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rd_hs)
         rdata <= rd_mux;  // held while rvalid waits
   end

   a_bvalid_hold : assert property (@(posedge clk) disable iff (!aresetn_local)
      bvalid && !bready |=> bvalid);

endmodule

/* rtl/chan_accum.sv */
`timescale 1ns/1ps

module chan_accum
(
   input  logic                    clk,
   input  logic                    aresetn_local,
   input  logic                    soft_clear,
   input  logic                    sample_valid,
   input  ltc_adc_pkg::adc_word_t  sample,
   input  ltc_reg_pkg::nsum_t      nsum,
   output logic                    sum_valid,
   output ltc_adc_pkg::fifo_word_t sum_word
);

   ltc_adc_pkg::fifo_word_t sum_q [ltc_adc_pkg::N_CHAN];  // running sum per channel
   ltc_reg_pkg::nsum_t      cnt_q [ltc_adc_pkg::N_CHAN];  // samples in this batch
   ltc_adc_pkg::chan_id_t   ch;
   ltc_adc_pkg::fifo_word_t ext;
   ltc_adc_pkg::fifo_word_t cur_sum;
   ltc_adc_pkg::fifo_word_t nxt_sum;
   ltc_reg_pkg::nsum_t      cur_cnt;
   logic                    take;   // sample counts toward a sum
   logic                    first;  // starts a batch
   logic                    last;   // completes nsum samples

   assign ch      = sample[ltc_adc_pkg::CHAN_LSB +: ltc_adc_pkg::CHAN_W];
   assign ext     = ltc_adc_pkg::sign_ext(sample);
   assign cur_sum = sum_q[ch];
   assign cur_cnt = cnt_q[ch];
   assign take    = sample_valid && (nsum != '0);
   assign first   = (cur_cnt == '0);
   assign last    = (cur_cnt + 1'b1 >= nsum);  // also ends a batch if nsum shrank

   // low bits keep the first sample's chan and softspan codes
   assign nxt_sum = first ? ext :
      {cur_sum[ltc_adc_pkg::FIFO_W-1:ltc_adc_pkg::SUM_LSB] +
       ext[ltc_adc_pkg::FIFO_W-1:ltc_adc_pkg::SUM_LSB],
       cur_sum[ltc_adc_pkg::SUM_LSB-1:0]};

   always_ff @(posedge clk or negedge aresetn_local)
   begin
      if (!aresetn_local)
      begin
         for (int i = 0; i < ltc_adc_pkg::N_CHAN; i++)
            cnt_q[i] <= '0;
         sum_valid <= 1'b0;
      end
      else if (soft_clear || nsum == '0)
      begin
         for (int i = 0; i < ltc_adc_pkg::N_CHAN; i++)
            cnt_q[i] <= '0;   // idle in raw mode
         sum_valid <= 1'b0;
      end
      else
      begin
         sum_valid <= take && last;
         if (take)
            cnt_q[ch] <= last ? '0 : cur_cnt + 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (take)
      begin
         sum_q[ch] <= nxt_sum;
         if (last)
            sum_word <= nxt_sum;  // one cycle after the closing sample
      end
   end

endmodule

/* rtl/sample_fifo.sv */
`timescale 1ns/1ps

module sample_fifo
(
   input  logic                     clk,
   input  logic                     aresetn_local,
   input  logic                     soft_clear,
   input  logic                     enable,
   input  logic                     write_block,
   input  logic                     fifo_rden,
   input  logic                     sample_valid,
   input  logic                     sum_valid,
   input  ltc_adc_pkg::adc_word_t   sample,
   input  ltc_adc_pkg::fifo_word_t  sum_word,
   input  ltc_reg_pkg::nsum_t       nsum,
   input  ltc_adc_pkg::fifo_count_t intr_depth,
   output ltc_adc_pkg::fifo_word_t  fifo_dout,
   output ltc_adc_pkg::fifo_count_t fifo_count,
   output logic                     fifo_not_empty,
   output logic                     fifo_full,
   output logic                     interrupt
);

   ltc_adc_pkg::fifo_word_t mem [ltc_adc_pkg::FIFO_DEPTH];
   ltc_adc_pkg::fifo_ptr_t  wr_ptr;
   ltc_adc_pkg::fifo_ptr_t  rd_ptr;
   ltc_adc_pkg::fifo_word_t din;
   logic                    raw_mode;
   logic                    push;   // a word is on offer
   logic                    wr_en;
   logic                    rd_en;

   assign raw_mode       = (nsum == '0);
   assign din            = raw_mode ? ltc_adc_pkg::sign_ext(sample) : sum_word;
   assign push           = raw_mode ? sample_valid : sum_valid;
   assign wr_en          = push && enable && !write_block && !fifo_full;  // full drops
   assign rd_en          = fifo_rden && fifo_not_empty;
   assign fifo_full      = (fifo_count == ltc_adc_pkg::fifo_count_t'(ltc_adc_pkg::FIFO_DEPTH));
   assign fifo_not_empty = (fifo_count != '0);
   assign interrupt      = (fifo_count > intr_depth);

   always_ff @(posedge clk or negedge aresetn_local)
   begin
      if (!aresetn_local)
      begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         fifo_count <= '0;
      end
      else if (soft_clear)
      begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         fifo_count <= '0;
      end
      else
      begin
         if (wr_en)
            wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
         if (rd_en)
            rd_ptr <= rd_ptr + 1'b1;
         case ({wr_en, rd_en})
            2'b10:   fifo_count <= fifo_count + 1'b1;
            2'b01:   fifo_count <= fifo_count - 1'b1;
            default: ;                // both or neither
         endcase
      end
   end

   // storage and registered read port
   always_ff @(posedge clk)
   begin
      if (wr_en)
         mem[wr_ptr] <= din;
      if (rd_en)
         fifo_dout <= mem[rd_ptr];
   end

   a_count_max : assert property (@(posedge clk) disable iff (!aresetn_local)
      fifo_count <= ltc_adc_pkg::fifo_count_t'(ltc_adc_pkg::FIFO_DEPTH));

   // a pop takes a stored word, pointers only meet when empty or full
   a_no_underflow : assert property (@(posedge clk) disable iff (!aresetn_local)
      rd_en |-> (rd_ptr != wr_ptr) || fifo_full);

endmodule

/* rtl/ltc2333_read_top.sv */
`timescale 1ns/1ps

module ltc2333_read_top
(
   input  logic                    clk,
   input  logic                    aresetn_local,
   input  logic                    cnv,
   input  logic                    scko,
   input  logic                    sdo,
   input  logic                    timetrig,
   input  logic                    write_block,
   input  logic                    fifo_rden,
   input  logic                    awvalid,
   output logic                    awready,
   input  ltc_reg_pkg::axi_addr_t  awaddr,
   input  logic                    wvalid,
   output logic                    wready,
   input  ltc_reg_pkg::axi_data_t  wdata,
   output logic                    bvalid,
   input  logic                    bready,
   output ltc_reg_pkg::axi_resp_t  bresp,
   input  logic                    arvalid,
   output logic                    arready,
   input  ltc_reg_pkg::axi_addr_t  araddr,
   output logic                    rvalid,
   input  logic                    rready,
   output ltc_reg_pkg::axi_data_t  rdata,
   output ltc_reg_pkg::axi_resp_t  rresp,
   output ltc_adc_pkg::fifo_word_t fifo_dout,
   output logic                    fifo_not_empty,
   output logic                    fifo_full,
   output logic                    interrupt
);

   logic                     sample_valid;  // capture to accum and fifo
   ltc_adc_pkg::adc_word_t   sample;
   logic                     sum_valid;
   ltc_adc_pkg::fifo_word_t  sum_word;
   logic                     enable;        // register side settings
   logic                     soft_clear;
   ltc_adc_pkg::fifo_count_t intr_depth;
   ltc_reg_pkg::nsum_t       nsum;
   ltc_adc_pkg::fifo_count_t fifo_count;    // back to occupancy register

   adc_capture adc_capture_inst
   (
      .clk, .aresetn_local, .cnv, .scko, .sdo, .timetrig, .soft_clear,
      .sample_valid, .sample
   );

   ltc_regs ltc_regs_inst
   (
      .clk, .aresetn_local,
      .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata,
      .bvalid, .bready, .bresp,
      .arvalid, .arready, .araddr, .rvalid, .rready, .rdata, .rresp,
      .fifo_count, .enable, .soft_clear, .intr_depth, .nsum
   );

   chan_accum chan_accum_inst
   (
      .clk, .aresetn_local, .soft_clear, .sample_valid, .sample, .nsum,
      .sum_valid, .sum_word
   );

   sample_fifo sample_fifo_inst
   (
      .clk, .aresetn_local, .soft_clear, .enable, .write_block, .fifo_rden,
      .sample_valid, .sum_valid, .sample, .sum_word, .nsum, .intr_depth,
      .fifo_dout, .fifo_count, .fifo_not_empty, .fifo_full, .interrupt
   );

endmodule

/* sim/tb_ltc2333_read.sv */
`timescale 1ns/1ps

module tb_ltc2333_read;

   //////////////////////////////////////////////////////////////////////
   // stimulus table, one row per test case
   //////////////////////////////////////////////////////////////////////
   typedef struct packed {
      logic [31:0] nsum;       // 0 = raw words
      logic        en;         // CTRL enable bit
      logic        blk;        // write_block level
      logic [7:0]  n_frames;
      logic [7:0]  trig_at;    // frame preceded by timetrig, ff = none
      logic [31:0] chan_seq;   // channel per frame, low nibble first
      logic        occ_check;  // OCC and interrupt after every frame
      logic        clear_end;  // soft reset before the drain
   } case_t;

   localparam int    N_CASES = 6;
   localparam case_t CASES [N_CASES] = '{
      //  nsum   en    blk   frames trig   channels       occ   clear
      '{32'd0, 1'b1, 1'b0, 8'd5,  8'd2,  32'h7654_3210, 1'b0, 1'b0},  // raw, trig drop
      '{32'd2, 1'b1, 1'b0, 8'd6,  8'hff, 32'h0032_3121, 1'b0, 1'b0},  // sums, interleaved
      '{32'd0, 1'b0, 1'b0, 8'd2,  8'hff, 32'h7654_3210, 1'b0, 1'b0},  // enable clear
      '{32'd0, 1'b1, 1'b1, 8'd2,  8'hff, 32'h7654_3210, 1'b0, 1'b0},  // write_block high
      '{32'd0, 1'b1, 1'b0, 8'd18, 8'hff, 32'h7654_3210, 1'b1, 1'b0},  // fill past full
      '{32'd0, 1'b1, 1'b0, 8'd3,  8'hff, 32'h7654_3210, 1'b0, 1'b1}   // soft reset
   };

   logic                     clk = 1'b0;
   logic                     aresetn_local;
   logic                     cnv;
   logic                     scko;
   logic                     sdo;
   logic                     timetrig;
   logic                     write_block;
   logic                     fifo_rden;
   logic                     awvalid;
   logic                     awready;
   ltc_reg_pkg::axi_addr_t   awaddr;
   logic                     wvalid;
   logic                     wready;
   ltc_reg_pkg::axi_data_t   wdata;
   logic                     bvalid;
   logic                     bready;
   ltc_reg_pkg::axi_resp_t   bresp;
   logic                     arvalid;
   logic                     arready;
   ltc_reg_pkg::axi_addr_t   araddr;
   logic                     rvalid;
   logic                     rready;
   ltc_reg_pkg::axi_data_t   rdata;
   ltc_reg_pkg::axi_resp_t   rresp;
   ltc_adc_pkg::fifo_word_t  fifo_dout;
   logic                     fifo_not_empty;
   logic                     fifo_full;
   logic                     interrupt;

   ltc_adc_pkg::fifo_word_t  exp_q [$];            // words the FIFO should hold
   logic [25:0]              acc_sum [8];          // reference sums, upper field only
   logic [5:0]               acc_low [8];          // first sample chan + span
   int                       acc_cnt [8];
   int                       seed;

   always #20 clk = ~clk;                          // 40 ns period

   ltc2333_read_top ltc2333_read_top_inst
   (
      .clk, .aresetn_local, .cnv, .scko, .sdo, .timetrig, .write_block, .fifo_rden,
      .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata, .bvalid, .bready, .bresp,
      .arvalid, .arready, .araddr, .rvalid, .rready, .rdata, .rresp,
      .fifo_dout, .fifo_not_empty, .fifo_full, .interrupt
   );

   //////////////////////////////////////////////////////////////////////
   // checks
   //////////////////////////////////////////////////////////////////////
   task automatic expect_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp)
      else
      begin
         $display("[FAIL] %0t ns: %s expected %h got %h", $time, what, exp, got);
         $display("TB FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic expect_true(input logic cond, input string msg);
      assert (cond)
      else
      begin
         $display("%0t ns: %s", $time, msg);
         $display("TB FAILED");
         $fatal(1, "check failed");
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // bus, ADC and FIFO drivers
   //////////////////////////////////////////////////////////////////////
   task automatic write_reg(input ltc_reg_pkg::axi_addr_t addr,
                            input ltc_reg_pkg::axi_data_t data);
      @(posedge clk);
      awaddr  <= addr;
      awvalid <= 1'b1;
      wdata   <= data;
      wvalid  <= 1'b1;
      bready  <= 1'b1;
      do @(negedge clk); while (!awready);      // ready pulses one cycle
      expect_eq("wready with awready", 32'(wready), 32'd1);
      @(posedge clk);
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      do @(negedge clk); while (!bvalid);
      expect_eq("bresp", 32'(bresp), 32'd0);     // OKAY
      @(posedge clk);                            // response taken here
      bready  <= 1'b0;
   endtask

   task automatic read_reg(input ltc_reg_pkg::axi_addr_t addr,
                           output ltc_reg_pkg::axi_data_t data);
      @(posedge clk);
      araddr  <= addr;
      arvalid <= 1'b1;
      rready  <= 1'b1;
      do @(negedge clk); while (!arready);
      @(posedge clk);
      arvalid <= 1'b0;
      do @(negedge clk); while (!rvalid);
      expect_eq("rresp", 32'(rresp), 32'd0);     // OKAY
      data = rdata;
      @(posedge clk);
      rready  <= 1'b0;
   endtask

   task automatic check_reg(input ltc_reg_pkg::axi_addr_t addr, input logic [31:0] exp,
                            input string what);
      ltc_reg_pkg::axi_data_t got;
      read_reg(addr, got);
      expect_eq(what, got, exp);
   endtask

   // cnv pulse, then 24 scko edges, 4 clk apart, msb first
   task automatic send_frame(input logic [23:0] word);
      @(posedge clk);
      cnv <= 1'b1;
      repeat (2) @(posedge clk);
      cnv <= 1'b0;
      for (int b = 23; b >= 0; b--)
      begin
         sdo <= word[b];                         // settles 2 clk before the edge
         repeat (2) @(posedge clk);
         scko <= ~scko;
         repeat (2) @(posedge clk);
      end
      repeat (8) @(posedge clk);                 // sync, capture, sum, fifo write
   endtask

   task automatic pop_word(output logic [31:0] w);
      @(posedge clk);
      fifo_rden <= 1'b1;
      @(posedge clk);
      fifo_rden <= 1'b0;
      @(negedge clk);
      w = fifo_dout;                             // valid the cycle after rden
   endtask

   // reference FIFO, gated and full writes dropped
   task automatic queue_expected(input case_t c, input logic [31:0] w);
      if (c.en && !c.blk && exp_q.size() < ltc_adc_pkg::FIFO_DEPTH)
         exp_q.push_back(w);
   endtask

   function automatic int total_frames();
      int n;
      n = 0;
      for (int i = 0; i < N_CASES; i++)
         n += int'(CASES[i].n_frames);
      return n;
   endfunction

   initial
   begin : watchdog
      repeat (total_frames() * 150 + 2000) @(posedge clk);
      $display("timeout: the test cases did not finish in time");
      $display("TB FAILED");
      $fatal(1, "watchdog expired");
   end

   //////////////////////////////////////////////////////////////////////
   // main sequence
   //////////////////////////////////////////////////////////////////////
   initial
   begin : main
      case_t                  c;
      logic [17:0]            val;
      logic [2:0]             ch;
      logic [2:0]             span;
      logic [23:0]            word;
      logic                   skip;
      ltc_reg_pkg::axi_data_t rd;
      seed          = 32'h6518;
      aresetn_local = 1'b0;
      cnv           = 1'b0;
      scko          = 1'b0;
      sdo           = 1'b0;
      timetrig      = 1'b0;
      write_block   = 1'b0;
      fifo_rden     = 1'b0;
      awvalid       = 1'b0;
      awaddr        = '0;
      wvalid        = 1'b0;
      wdata         = '0;
      bready        = 1'b0;
      arvalid       = 1'b0;
      araddr        = '0;
      rready        = 1'b0;
      repeat (4) @(posedge clk);
      aresetn_local <= 1'b1;
      repeat (2) @(posedge clk);

      // bus idle before the first transfer
      @(negedge clk);
      expect_eq("awready after reset", 32'(awready), 32'd0);
      expect_eq("wready after reset", 32'(wready), 32'd0);
      expect_eq("arready after reset", 32'(arready), 32'd0);
      expect_eq("bvalid after reset", 32'(bvalid), 32'd0);
      expect_eq("rvalid after reset", 32'(rvalid), 32'd0);

      check_reg(ltc_reg_pkg::REG_CTRL, 32'd0, "CTRL after reset");
      check_reg(ltc_reg_pkg::REG_INTR_DEPTH, 32'd1, "INTR_DEPTH after reset");
      check_reg(ltc_reg_pkg::REG_NSUM, 32'd0, "NSUM after reset");
      check_reg(ltc_reg_pkg::REG_OCC, 32'd0, "OCC after reset");
      @(negedge clk);
      expect_eq("fifo_not_empty after reset", 32'(fifo_not_empty), 32'd0);
      expect_eq("interrupt after reset", 32'(interrupt), 32'd0);
      expect_eq("fifo_full after reset", 32'(fifo_full), 32'd0);
      write_reg(ltc_reg_pkg::REG_INTR_DEPTH, 32'd3);  // irq above 3 words

      for (int k = 0; k < N_CASES; k++)
      begin
         c    = CASES[k];
         skip = 1'b0;
         for (int j = 0; j < 8; j++)
            acc_cnt[j] = 0;
         write_reg(ltc_reg_pkg::REG_NSUM, c.nsum);
         write_reg(ltc_reg_pkg::REG_CTRL, {30'd0, c.en, 1'b0});
         @(posedge clk);
         write_block <= c.blk;

         for (int i = 0; i < int'(c.n_frames); i++)
         begin
            val  = 18'($random(seed));
            span = 3'($random(seed));
            ch   = c.chan_seq[4 * (i % 8) +: 3];
            word = {val, ch, span};
            if (i == int'(c.trig_at))
            begin
               @(posedge clk);
               timetrig <= 1'b1;                 // next frame is dropped
               @(posedge clk);
               timetrig <= 1'b0;
               skip = 1'b1;
            end
            send_frame(word);
            if (skip)
               skip = 1'b0;
            else if (c.nsum == 32'd0)
               queue_expected(c, {{8{word[23]}}, word});
            else
            begin
               if (acc_cnt[ch] == 0)
               begin
                  acc_sum[ch] = {{8{val[17]}}, val};
                  acc_low[ch] = word[5:0];
               end
               else
                  acc_sum[ch] = acc_sum[ch] + {{8{val[17]}}, val};
               acc_cnt[ch]++;
               if (acc_cnt[ch] == int'(c.nsum))
               begin
                  queue_expected(c, {acc_sum[ch], acc_low[ch]});
                  acc_cnt[ch] = 0;
               end
            end
            if (c.occ_check)
            begin
               check_reg(ltc_reg_pkg::REG_OCC, 32'(exp_q.size()), "OCC");
               @(negedge clk);
               expect_eq("interrupt", 32'(interrupt), 32'(exp_q.size() > 3));
            end
         end

         if (c.occ_check)
         begin
            check_reg(ltc_reg_pkg::REG_OCC, 32'(ltc_adc_pkg::FIFO_DEPTH), "OCC when full");
            @(negedge clk);
            expect_eq("fifo_full", 32'(fifo_full), 32'd1);
         end
         if (c.clear_end)
         begin
            write_reg(ltc_reg_pkg::REG_CTRL, {30'd0, c.en, 1'b1});
            check_reg(ltc_reg_pkg::REG_OCC, 32'd0, "OCC after soft reset");
            check_reg(ltc_reg_pkg::REG_CTRL, {30'd0, c.en, 1'b0}, "CTRL after soft reset");
            exp_q.delete();
         end

         // drain and compare in order
         @(negedge clk);
         while (fifo_not_empty)
         begin
            expect_true(exp_q.size() != 0,
                        "FIFO holds a word that no frame should have written");
            pop_word(rd);
            expect_eq("fifo word", rd, exp_q.pop_front());
         end
         expect_true(exp_q.size() == 0, "FIFO ran empty before all expected words came out");
         @(posedge clk);
         write_block <= 1'b0;
      end

      $display("TB PASSED");
      $finish;
   end

endmodule

/* filelist.f */
rtl/ltc_adc_pkg.sv
rtl/ltc_reg_pkg.sv
rtl/adc_capture.sv
rtl/ltc_regs.sv
rtl/chan_accum.sv
rtl/sample_fifo.sv
rtl/ltc2333_read_top.sv
sim/tb_ltc2333_read.sv

/* Makefile */
# Verilator build and run of the ADC reader testbench

VERILATOR ?= verilator
TOP       ?= tb_ltc2333_read
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# a $fatal in the testbench gives a non-zero exit status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
